// ==== hw/pipe_settings.svh ====
`ifndef PIPE_SETTINGS_SVH
`define PIPE_SETTINGS_SVH

// Datapath and instruction width
`define PIPE_DATA_W 16
// Sequence tag width, wraps around
`define PIPE_TAG_W 4
`define PIPE_REG_AW 3
`define PIPE_MEM_AW 4
// Queue depth equals the initial input credits
`define PIPE_IN_CREDITS 4
`define PIPE_TRACE_CREDITS 4
`define PIPE_STALL_W 4

`endif

// ==== hw/pipe_pkg.sv ====
package pipe_pkg;

    // Opcodes live in the top three bits of the instruction word
    typedef enum logic [2:0] {
        OP_ADD, OP_SUB, OP_AND, OP_OR,
        OP_XOR, OP_LDI, OP_LD, OP_ST
    } opcode_t;

    // Pipeline stages, used for per-tag occupancy
    typedef enum logic [2:0] {
        ST_FETCH, ST_DECODE, ST_EXECUTE, ST_MEMORY, ST_WRITEBACK
    } stage_t;

    // Field positions in the 16-bit instruction word
    localparam int unsigned OPC_LSB = 13;
    localparam int unsigned RD_LSB  = 10;
    localparam int unsigned RS1_LSB = 7;
    localparam int unsigned RS2_LSB = 4;
    // Load immediate value width, zero-extended
    localparam int unsigned IMM_W   = 7;

endpackage

// ==== hw/fetch_queue.sv ====
`timescale 1ns/100ps
`include "pipe_settings.svh"

module fetch_queue (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    instr_valid,
    input  logic [`PIPE_DATA_W-1:0] instr_word,
    input  logic                    hold,
    input  logic                    dec_stall,
    output logic                    instr_credit,
    output logic                    fq_valid,
    output logic [`PIPE_TAG_W-1:0]  fq_tag,
    output logic [`PIPE_DATA_W-1:0] fq_word
);

    localparam int QAW = $clog2(`PIPE_IN_CREDITS);

    logic [`PIPE_DATA_W-1:0] q_word [`PIPE_IN_CREDITS];
    logic [`PIPE_TAG_W-1:0]  q_tag  [`PIPE_IN_CREDITS];
    logic [QAW-1:0]          wr_ptr;
    logic [QAW-1:0]          rd_ptr;
    logic [QAW:0]            count;
    logic [`PIPE_TAG_W-1:0]  next_tag;
    logic                    take;

    assign fq_valid = (count != '0);
    assign fq_word  = q_word[rd_ptr];
    assign fq_tag   = q_tag[rd_ptr];

    // Head moves into decode unless decode is stalled or the pipe is held
    assign take = fq_valid && !hold && !dec_stall;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            count        <= '0;
            next_tag     <= '0;
            instr_credit <= 1'b0;
        end else begin
            // One credit back per entry handed to decode
            instr_credit <= take;
            if (instr_valid) begin
                wr_ptr   <= wr_ptr + 1'b1;
                next_tag <= next_tag + 1'b1;
            end
            if (take) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + (QAW+1)'(instr_valid) - (QAW+1)'(take);
        end
    end

    // Sender only writes while holding a credit, so a slot is always free
    always_ff @(posedge clk) begin
        if (instr_valid) begin
            q_word[wr_ptr] <= instr_word;
            q_tag[wr_ptr]  <= next_tag;
        end
    end

endmodule

// ==== hw/decode_stage.sv ====
`timescale 1ns/100ps
`include "pipe_settings.svh"

module decode_stage (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     hold,
    input  logic                     fq_valid,
    input  logic [`PIPE_TAG_W-1:0]   fq_tag,
    input  logic [`PIPE_DATA_W-1:0]  fq_word,
    output logic                     dec_stall,
    input  logic                     ex_valid,
    input  logic                     ex_wen,
    input  logic [`PIPE_REG_AW-1:0]  ex_rd,
    input  logic                     mem_valid,
    input  logic                     mem_wen,
    input  logic [`PIPE_REG_AW-1:0]  mem_rd,
    input  logic                     wb_valid,
    input  logic                     wb_wen,
    input  logic [`PIPE_REG_AW-1:0]  wb_rd,
    input  logic [`PIPE_DATA_W-1:0]  wb_result,
    output logic                     dx_valid,
    output logic [`PIPE_TAG_W-1:0]   dx_tag,
    output pipe_pkg::opcode_t        dx_opcode,
    output logic [`PIPE_REG_AW-1:0]  dx_rd,
    output logic                     dx_wen,
    output logic [`PIPE_DATA_W-1:0]  dx_a,
    output logic [`PIPE_DATA_W-1:0]  dx_b,
    output logic [`PIPE_DATA_W-1:0]  dx_imm,
    output logic [`PIPE_STALL_W-1:0] dx_stall_cnt
);

    localparam int NREGS = 1 << `PIPE_REG_AW;

    logic [`PIPE_DATA_W-1:0]  rf [NREGS];
    logic                     d_valid;
    logic [`PIPE_DATA_W-1:0]  d_word;
    logic [`PIPE_TAG_W-1:0]   d_tag;
    logic [`PIPE_STALL_W-1:0] d_stall;
    pipe_pkg::opcode_t        d_op;
    logic [`PIPE_REG_AW-1:0]  d_rd;
    logic [`PIPE_REG_AW-1:0]  d_rs1;
    logic [`PIPE_REG_AW-1:0]  d_rs2;
    logic                     use_rs1;
    logic                     use_rs2;
    logic                     hazard;

    function automatic logic conflict(input logic v, input logic wen,
                                      input logic [`PIPE_REG_AW-1:0] rd,
                                      input logic u1, input logic u2,
                                      input logic [`PIPE_REG_AW-1:0] rs1,
                                      input logic [`PIPE_REG_AW-1:0] rs2);
        return v && wen && ((u1 && rd == rs1) || (u2 && rd == rs2));
    endfunction

    assign d_op  = pipe_pkg::opcode_t'(d_word[pipe_pkg::OPC_LSB +: $bits(pipe_pkg::opcode_t)]);
    assign d_rd  = d_word[pipe_pkg::RD_LSB +: `PIPE_REG_AW];
    assign d_rs1 = d_word[pipe_pkg::RS1_LSB +: `PIPE_REG_AW];
    assign d_rs2 = d_word[pipe_pkg::RS2_LSB +: `PIPE_REG_AW];

    // Load immediate reads nothing, load reads only its address register
    assign use_rs1 = (d_op != pipe_pkg::OP_LDI);
    assign use_rs2 = (d_op != pipe_pkg::OP_LDI) && (d_op != pipe_pkg::OP_LD);

    // No forwarding, so wait until every older writer has reached the register file
    assign hazard = conflict(dx_valid, dx_wen, dx_rd, use_rs1, use_rs2, d_rs1, d_rs2)
                  | conflict(ex_valid, ex_wen, ex_rd, use_rs1, use_rs2, d_rs1, d_rs2)
                  | conflict(mem_valid, mem_wen, mem_rd, use_rs1, use_rs2, d_rs1, d_rs2);

    assign dec_stall = d_valid && hazard;

    always_ff @(posedge clk) begin
        if (rst) begin
            d_valid  <= 1'b0;
            dx_valid <= 1'b0;
            for (int i = 0; i < NREGS; i++) begin
                rf[i] <= '0;
            end
        end else begin
            if (wb_valid && wb_wen) begin
                rf[wb_rd] <= wb_result;
            end
            if (!hold) begin
                // Bubble into execute while the interlock holds
                dx_valid <= d_valid && !hazard;
                if (!dec_stall) begin
                    d_valid <= fq_valid;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            if (dec_stall) begin
                if (d_stall != '1) begin
                    d_stall <= d_stall + 1'b1;
                end
            end else begin
                d_word       <= fq_word;
                d_tag        <= fq_tag;
                d_stall      <= '0;
                dx_tag       <= d_tag;
                dx_opcode    <= d_op;
                dx_rd        <= d_rd;
                dx_wen       <= (d_op != pipe_pkg::OP_ST);
                dx_a         <= rf[d_rs1];
                dx_b         <= rf[d_rs2];
                dx_imm       <= {{(`PIPE_DATA_W - pipe_pkg::IMM_W){1'b0}},
                                 d_word[pipe_pkg::IMM_W-1:0]};
                dx_stall_cnt <= d_stall;
            end
        end
    end

endmodule

// ==== hw/execute_stage.sv ====
`timescale 1ns/100ps
`include "pipe_settings.svh"

module execute_stage (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     hold,
    input  logic                     dx_valid,
    input  logic [`PIPE_TAG_W-1:0]   dx_tag,
    input  pipe_pkg::opcode_t        dx_opcode,
    input  logic [`PIPE_REG_AW-1:0]  dx_rd,
    input  logic                     dx_wen,
    input  logic [`PIPE_DATA_W-1:0]  dx_a,
    input  logic [`PIPE_DATA_W-1:0]  dx_b,
    input  logic [`PIPE_DATA_W-1:0]  dx_imm,
    input  logic [`PIPE_STALL_W-1:0] dx_stall_cnt,
    output logic                     ex_valid,
    output logic [`PIPE_TAG_W-1:0]   ex_tag,
    output pipe_pkg::opcode_t        ex_opcode,
    output logic [`PIPE_REG_AW-1:0]  ex_rd,
    output logic                     ex_wen,
    output logic [`PIPE_DATA_W-1:0]  ex_result,
    output logic [`PIPE_MEM_AW-1:0]  ex_addr,
    output logic [`PIPE_DATA_W-1:0]  ex_store_data,
    output logic [`PIPE_STALL_W-1:0] ex_stall_cnt
);

    logic [`PIPE_DATA_W-1:0] alu_out;

    always_comb begin
        case (dx_opcode)
            pipe_pkg::OP_ADD: alu_out = dx_a + dx_b;
            pipe_pkg::OP_SUB: alu_out = dx_a - dx_b;
            pipe_pkg::OP_AND: alu_out = dx_a & dx_b;
            pipe_pkg::OP_OR:  alu_out = dx_a | dx_b;
            pipe_pkg::OP_XOR: alu_out = dx_a ^ dx_b;
            pipe_pkg::OP_LDI: alu_out = dx_imm;
            // Loads and stores get their result in the memory stage
            default:          alu_out = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_valid <= 1'b0;
        end else if (!hold) begin
            ex_valid <= dx_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            ex_tag        <= dx_tag;
            ex_opcode     <= dx_opcode;
            ex_rd         <= dx_rd;
            ex_wen        <= dx_wen;
            ex_result     <= alu_out;
            ex_addr       <= dx_a[`PIPE_MEM_AW-1:0];
            ex_store_data <= dx_b;
            ex_stall_cnt  <= dx_stall_cnt;
        end
    end

endmodule

// ==== hw/memory_stage.sv ====
`timescale 1ns/100ps
`include "pipe_settings.svh"

module memory_stage (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     hold,
    input  logic                     ex_valid,
    input  logic [`PIPE_TAG_W-1:0]   ex_tag,
    input  pipe_pkg::opcode_t        ex_opcode,
    input  logic [`PIPE_REG_AW-1:0]  ex_rd,
    input  logic                     ex_wen,
    input  logic [`PIPE_DATA_W-1:0]  ex_result,
    input  logic [`PIPE_MEM_AW-1:0]  ex_addr,
    input  logic [`PIPE_DATA_W-1:0]  ex_store_data,
    input  logic [`PIPE_STALL_W-1:0] ex_stall_cnt,
    output logic                     mem_valid,
    output logic [`PIPE_TAG_W-1:0]   mem_tag,
    output pipe_pkg::opcode_t        mem_opcode,
    output logic [`PIPE_REG_AW-1:0]  mem_rd,
    output logic                     mem_wen,
    output logic [`PIPE_DATA_W-1:0]  mem_result,
    output logic [`PIPE_STALL_W-1:0] mem_stall_cnt
);

    localparam int NWORDS = 1 << `PIPE_MEM_AW;

    logic [`PIPE_DATA_W-1:0] dmem [NWORDS];

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_valid <= 1'b0;
            for (int i = 0; i < NWORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (!hold) begin
            mem_valid <= ex_valid;
            if (ex_valid && ex_opcode == pipe_pkg::OP_ST) begin
                dmem[ex_addr] <= ex_store_data;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            mem_tag       <= ex_tag;
            mem_opcode    <= ex_opcode;
            mem_rd        <= ex_rd;
            mem_wen       <= ex_wen;
            mem_stall_cnt <= ex_stall_cnt;
            case (ex_opcode)
                pipe_pkg::OP_LD: mem_result <= dmem[ex_addr];
                // A store reports the value it wrote
                pipe_pkg::OP_ST: mem_result <= ex_store_data;
                default:         mem_result <= ex_result;
            endcase
        end
    end

endmodule

// ==== hw/retire_tracker.sv ====
`timescale 1ns/100ps
`include "pipe_settings.svh"

module retire_tracker (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     trace_credit,
    input  logic                     mem_valid,
    input  logic [`PIPE_TAG_W-1:0]   mem_tag,
    input  pipe_pkg::opcode_t        mem_opcode,
    input  logic [`PIPE_REG_AW-1:0]  mem_rd,
    input  logic                     mem_wen,
    input  logic [`PIPE_DATA_W-1:0]  mem_result,
    input  logic [`PIPE_STALL_W-1:0] mem_stall_cnt,
    output logic                     hold,
    output logic                     wb_valid,
    output logic                     wb_wen,
    output logic [`PIPE_REG_AW-1:0]  wb_rd,
    output logic [`PIPE_DATA_W-1:0]  wb_result,
    output logic                     trace_valid,
    output logic [`PIPE_TAG_W-1:0]   trace_tag,
    output pipe_pkg::opcode_t        trace_opcode,
    output logic [`PIPE_REG_AW-1:0]  trace_rd,
    output logic [`PIPE_DATA_W-1:0]  trace_result,
    output logic [`PIPE_STALL_W-1:0] trace_stall_cnt,
    output logic                     trace_order_err
);

    localparam int CW    = $clog2(`PIPE_TRACE_CREDITS + 1);
    localparam int NTAGS = 1 << `PIPE_TAG_W;

    logic [CW-1:0]          credits;
    pipe_pkg::stage_t       occ [NTAGS];
    logic [`PIPE_TAG_W-1:0] prev_tag;
    logic                   order_ok;
    logic                   retire;

    // Exactly one entry is in writeback state, the last retired tag
    assign prev_tag = mem_tag - 1'b1;
    assign order_ok = (occ[prev_tag] == pipe_pkg::ST_WRITEBACK);

    assign hold   = mem_valid && (credits == '0);
    assign retire = mem_valid && (credits != '0) && order_ok;

    // Register file write only in the retire cycle
    assign wb_valid  = retire;
    assign wb_wen    = mem_wen;
    assign wb_rd     = mem_rd;
    assign wb_result = mem_result;

    assign trace_valid     = retire;
    assign trace_tag       = mem_tag;
    assign trace_opcode    = mem_opcode;
    assign trace_rd        = mem_rd;
    assign trace_result    = mem_result;
    assign trace_stall_cnt = mem_stall_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            credits         <= CW'(`PIPE_TRACE_CREDITS);
            trace_order_err <= 1'b0;
            for (int i = 0; i < NTAGS - 1; i++) begin
                occ[i] <= pipe_pkg::ST_FETCH;
            end
            // Tag zero comes first, so its predecessor counts as retired
            occ[NTAGS-1] <= pipe_pkg::ST_WRITEBACK;
        end else begin
            credits <= credits + CW'(trace_credit) - CW'(retire);
            if (mem_valid && !order_ok) begin
                trace_order_err <= 1'b1;
            end
            if (retire) begin
                occ[prev_tag] <= pipe_pkg::ST_FETCH;
                occ[mem_tag]  <= pipe_pkg::ST_WRITEBACK;
            end
        end
    end

endmodule

// ==== hw/pipe_top.sv ====
`timescale 1ns/100ps
`include "pipe_settings.svh"

module pipe_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     instr_valid,
    input  logic [`PIPE_DATA_W-1:0]  instr_word,
    output logic                     instr_credit,
    output logic                     trace_valid,
    output logic [`PIPE_TAG_W-1:0]   trace_tag,
    output pipe_pkg::opcode_t        trace_opcode,
    output logic [`PIPE_REG_AW-1:0]  trace_rd,
    output logic [`PIPE_DATA_W-1:0]  trace_result,
    output logic [`PIPE_STALL_W-1:0] trace_stall_cnt,
    input  logic                     trace_credit,
    output logic                     trace_order_err
);

    // Global freeze and decode interlock
    logic                     hold;
    logic                     dec_stall;

    // Queue head
    logic                     fq_valid;
    logic [`PIPE_TAG_W-1:0]   fq_tag;
    logic [`PIPE_DATA_W-1:0]  fq_word;

    // Execute stage register
    logic                     dx_valid;
    logic [`PIPE_TAG_W-1:0]   dx_tag;
    pipe_pkg::opcode_t        dx_opcode;
    logic [`PIPE_REG_AW-1:0]  dx_rd;
    logic                     dx_wen;
    logic [`PIPE_DATA_W-1:0]  dx_a;
    logic [`PIPE_DATA_W-1:0]  dx_b;
    logic [`PIPE_DATA_W-1:0]  dx_imm;
    logic [`PIPE_STALL_W-1:0] dx_stall_cnt;

    // Memory stage register
    logic                     ex_valid;
    logic [`PIPE_TAG_W-1:0]   ex_tag;
    pipe_pkg::opcode_t        ex_opcode;
    logic [`PIPE_REG_AW-1:0]  ex_rd;
    logic                     ex_wen;
    logic [`PIPE_DATA_W-1:0]  ex_result;
    logic [`PIPE_MEM_AW-1:0]  ex_addr;
    logic [`PIPE_DATA_W-1:0]  ex_store_data;
    logic [`PIPE_STALL_W-1:0] ex_stall_cnt;

    // Writeback stage register
    logic                     mem_valid;
    logic [`PIPE_TAG_W-1:0]   mem_tag;
    pipe_pkg::opcode_t        mem_opcode;
    logic [`PIPE_REG_AW-1:0]  mem_rd;
    logic                     mem_wen;
    logic [`PIPE_DATA_W-1:0]  mem_result;
    logic [`PIPE_STALL_W-1:0] mem_stall_cnt;

    // Register file write port
    logic                     wb_valid;
    logic                     wb_wen;
    logic [`PIPE_REG_AW-1:0]  wb_rd;
    logic [`PIPE_DATA_W-1:0]  wb_result;

    fetch_queue    u_fetch   (.*);
    decode_stage   u_decode  (.*);
    execute_stage  u_execute (.*);
    memory_stage   u_memory  (.*);
    retire_tracker u_retire  (.*);

endmodule

// ==== verif/pipe_tb.sv ====
`timescale 1ns/100ps
`include "pipe_settings.svh"

module pipe_tb;

    localparam int NUM_INSTR      = 300;
    localparam int TIMEOUT_CYCLES = 60 * NUM_INSTR + 500;
    localparam int DRAIN_CYCLES   = 8;

    // Expected retire record plus the stall bounds from the dependency rules
    typedef struct packed {
        logic [`PIPE_TAG_W-1:0]  tag;
        logic [2:0]              op;
        logic [`PIPE_REG_AW-1:0] rd;
        logic [`PIPE_DATA_W-1:0] result;
        logic                    no_stall;
        logic                    must_stall;
    } record_t;

    logic                     clk          = 1'b0;
    logic                     rst          = 1'b1;
    logic                     instr_valid  = 1'b0;
    logic [`PIPE_DATA_W-1:0]  instr_word   = '0;
    logic                     trace_credit = 1'b0;
    logic                     instr_credit;
    logic                     trace_valid;
    logic [`PIPE_TAG_W-1:0]   trace_tag;
    pipe_pkg::opcode_t        trace_opcode;
    logic [`PIPE_REG_AW-1:0]  trace_rd;
    logic [`PIPE_DATA_W-1:0]  trace_result;
    logic [`PIPE_STALL_W-1:0] trace_stall_cnt;
    logic                     trace_order_err;

    // Reference model, updated in program order when an instruction is sent
    logic [`PIPE_DATA_W-1:0]  model_rf  [1 << `PIPE_REG_AW];
    logic [`PIPE_DATA_W-1:0]  model_mem [1 << `PIPE_MEM_AW];
    logic                     stored    [1 << `PIPE_MEM_AW];
    logic [`PIPE_REG_AW-1:0]  wr_hist   [3];
    logic                     wr_hist_v [3];
    logic                     prev_wen;
    logic [`PIPE_REG_AW-1:0]  prev_rd;
    record_t                  exp_q [$];
    pipe_pkg::stage_t         retire_stage = pipe_pkg::ST_WRITEBACK;

    int seed              = 94200;
    int next_tag          = 0;
    int cycle_count       = 0;
    int sent              = 0;
    int returned          = 0;
    int retired           = 0;
    int in_credits        = `PIPE_IN_CREDITS;
    int trace_outstanding = `PIPE_TRACE_CREDITS;
    int pending_return    = 0;
    int withhold_left     = 0;
    int drain_cycles      = 0;
    int load_hits         = 0;
    int dependent         = 0;

    pipe_top dut0 (.*);

    always #5 clk = ~clk;

    task automatic check_value(input logic [31:0] expected, input logic [31:0] actual,
                               input string what);
        if (expected !== actual) begin
            $display("mismatch at %0t: %s, expected %0h, got %0h", $time, what, expected, actual);
            $display("Test failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic stop_with_error(input string why);
        $display("Error at %0t: %s", $time, why);
        $display("Test failed");
        $fatal(1, "run stopped");
    endtask

    task automatic clear_model();
        for (int i = 0; i < (1 << `PIPE_REG_AW); i++) begin
            model_rf[i] = '0;
        end
        for (int i = 0; i < (1 << `PIPE_MEM_AW); i++) begin
            model_mem[i] = '0;
            stored[i]    = 1'b0;
        end
        for (int i = 0; i < 3; i++) begin
            wr_hist_v[i] = 1'b0;
        end
        prev_wen = 1'b0;
    endtask

    task automatic send_instruction();
        int                      r;
        logic [`PIPE_DATA_W-1:0] word;
        pipe_pkg::opcode_t       op;
        logic [`PIPE_REG_AW-1:0] rd;
        logic [`PIPE_REG_AW-1:0] rs1;
        logic [`PIPE_REG_AW-1:0] rs2;
        logic [`PIPE_DATA_W-1:0] a;
        logic [`PIPE_DATA_W-1:0] b;
        logic                    use1;
        logic                    use2;
        record_t                 rec;
        r    = $random(seed);
        word = r[15:0];
        op   = pipe_pkg::opcode_t'(word[15:13]);
        rd   = word[12:10];
        rs1  = word[9:7];
        rs2  = word[6:4];
        a    = model_rf[rs1];
        b    = model_rf[rs2];
        // Load immediate reads no register, load reads only its address
        use1 = (op != pipe_pkg::OP_LDI);
        use2 = use1 && (op != pipe_pkg::OP_LD);
        case (op)
            pipe_pkg::OP_ADD: rec.result = a + b;
            pipe_pkg::OP_SUB: rec.result = a - b;
            pipe_pkg::OP_AND: rec.result = a & b;
            pipe_pkg::OP_OR:  rec.result = a | b;
            pipe_pkg::OP_XOR: rec.result = a ^ b;
            pipe_pkg::OP_LDI: rec.result = {9'd0, word[6:0]};
            pipe_pkg::OP_LD: begin
                rec.result = model_mem[a[3:0]];
                if (stored[a[3:0]]) begin
                    load_hits++;
                end
            end
            default: begin
                rec.result        = b;
                model_mem[a[3:0]] = b;
                stored[a[3:0]]    = 1'b1;
            end
        endcase
        rec.tag        = next_tag[`PIPE_TAG_W-1:0];
        rec.op         = word[15:13];
        rec.rd         = rd;
        rec.no_stall   = 1'b1;
        for (int i = 0; i < 3; i++) begin
            if (wr_hist_v[i] && ((use1 && wr_hist[i] == rs1) || (use2 && wr_hist[i] == rs2))) begin
                rec.no_stall = 1'b0;
            end
        end
        rec.must_stall = prev_wen && ((use1 && prev_rd == rs1) || (use2 && prev_rd == rs2));
        exp_q.push_back(rec);
        if (op != pipe_pkg::OP_ST) begin
            model_rf[rd] = rec.result;
            for (int i = 2; i > 0; i--) begin
                wr_hist[i]   = wr_hist[i-1];
                wr_hist_v[i] = wr_hist_v[i-1];
            end
            wr_hist[0]   = rd;
            wr_hist_v[0] = 1'b1;
        end
        prev_wen    = (op != pipe_pkg::OP_ST);
        prev_rd     = rd;
        next_tag    = next_tag + 1;
        instr_word  = word;
        instr_valid = 1'b1;
    endtask

    task automatic check_trace();
        record_t           rec;
        pipe_pkg::opcode_t exp_op;
        string             what;
        check_value(32'd0, 32'(trace_order_err), "trace_order_err level");
        if (trace_valid && trace_outstanding == 0) begin
            stop_with_error("trace_valid raised while no trace credit was outstanding");
        end else if (trace_valid && exp_q.size() == 0) begin
            stop_with_error("retire record arrived with no instruction left in flight");
        end else if (trace_valid) begin
            rec    = exp_q.pop_front();
            exp_op = pipe_pkg::opcode_t'(rec.op);
            retired++;
            trace_outstanding--;
            pending_return++;
            what = $sformatf("%s record %0d (%s)", retire_stage.name(), retired, exp_op.name());
            check_value(32'(rec.tag), 32'(trace_tag), {what, " tag"});
            check_value(32'(rec.op), 32'(trace_opcode), {what, " opcode"});
            check_value(32'(rec.rd), 32'(trace_rd), {what, " rd"});
            check_value(32'(rec.result), 32'(trace_result), {what, " result"});
            if (rec.no_stall) begin
                check_value(32'd0, 32'(trace_stall_cnt), {what, " stall count"});
            end
            if (rec.must_stall) begin
                dependent++;
                check_value(32'd1, 32'(trace_stall_cnt != '0), {what, " stalled flag"});
            end
        end
    endtask

    task automatic return_trace_credits();
        int r;
        r            = $random(seed);
        trace_credit = 1'b0;
        if (withhold_left > 0) begin
            withhold_left--;
        end else if ((r & 63) == 0) begin
            // Long stretch without credits, backs up the whole pipeline
            withhold_left = 30 + ((r >> 6) & 63);
        end else if (pending_return > 0 && ((r >> 12) & 3) != 0) begin
            trace_credit = 1'b1;
            pending_return--;
            trace_outstanding++;
        end
    endtask

    task automatic finish_run();
        $display("%0d retired, %0d dependent, %0d loads of stored words", retired, dependent,
                 load_hits);
        if (in_credits == `PIPE_IN_CREDITS && exp_q.size() == 0 && load_hits > 0) begin
            $display("Test passed");
            $finish;
        end else begin
            $display("After drain: %0d input credits held, %0d records missing, %0d load hits",
                     in_credits, exp_q.size(), load_hits);
            $display("Test failed");
            $fatal(1, "drain check");
        end
    endtask

    // Everything is sampled and driven on the falling edge
    always @(negedge clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            stop_with_error($sformatf("timeout with %0d of %0d instructions retired",
                                      retired, NUM_INSTR));
        end else if (rst) begin
            clear_model();
            if (cycle_count == 4) begin
                rst = 1'b0;
            end
        end else begin
            check_trace();
            return_trace_credits();
            if (instr_credit) begin
                returned++;
                in_credits++;
                if (returned > sent) begin
                    stop_with_error("more input credits returned than instructions sent");
                end
            end
            instr_valid = 1'b0;
            if (sent < NUM_INSTR && in_credits > 0) begin
                send_instruction();
                sent++;
                in_credits--;
            end
            if (retired == NUM_INSTR) begin
                drain_cycles++;
                if (drain_cycles == DRAIN_CYCLES) begin
                    finish_run();
                end
            end
        end
    end

endmodule

// ==== verilog.f ====
+incdir+hw
hw/pipe_pkg.sv
hw/fetch_queue.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/memory_stage.sv
hw/retire_tracker.sv
hw/pipe_top.sv
verif/pipe_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module pipe_tb -f verilog.f -o pipe_sim
./obj_dir/pipe_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "Test passed" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log" >&2
exit 1
